// ==== meter_pkg.sv ====
package meter_pkg;

    localparam int TIME_W = 14;                  // enough bits for 9999 seconds
    localparam int BCD_W  = 16;                  // four packed bcd digits

    typedef logic [TIME_W-1:0] time_t;           // remaining time in seconds

    localparam time_t TIME_MAX = 14'd9999;       // largest value four digits can show

    // coin values in seconds
    localparam time_t COIN_1 = 14'd60;
    localparam time_t COIN_2 = 14'd120;
    localparam time_t COIN_3 = 14'd180;
    localparam time_t COIN_4 = 14'd300;

    localparam time_t PRESET_SHORT = 14'd16;     // preset_16 load value
    localparam time_t PRESET_LONG  = 14'd150;    // preset_150 load value

    // clk runs at 100 Hz
    localparam int CLKS_PER_SEC  = 100;
    localparam int CLKS_PER_HALF = 50;
    localparam int TICK_W        = $clog2(CLKS_PER_SEC);  // tick counter width

    localparam time_t SLOW_BLINK_LIMIT = 14'd180;  // top of the slow blink range

    typedef enum logic [1:0] {
        IDLE = 2'd0,                             // no time left, waiting for coins
        HELD = 2'd1,                             // coin accepted, waiting for release
        RUN  = 2'd2                              // counting down
    } meter_state_t;

    typedef logic [3:0] bcd_digit_t;             // one decimal digit

    typedef bcd_digit_t [3:0] bcd_time_t;        // index 0 holds the ones digit

endpackage

// ==== timer_if.sv ====
`timescale 1ns/1ps

interface timer_if import meter_pkg::*;;

    logic  load;                                 // replace time with amount
    logic  add;                                  // add amount, saturating
    time_t amount;                               // seconds for load or add
    logic  count_en;                             // decrement on each second tick
    logic  is_zero;                              // counter holds zero

    modport ctrl (
        output load,
        output add,
        output amount,
        output count_en,
        input  is_zero
    );

    modport counter (
        input  load,
        input  add,
        input  amount,
        input  count_en,
        output is_zero
    );

endinterface

// ==== tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen import meter_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic tick_sec,                       // one pulse per second
    output logic tick_half                       // one pulse per half second
);

    logic [TICK_W-1:0] cnt;                      // free running, modulo CLKS_PER_SEC
    logic              at_wrap;
    logic              at_mid;

    assign at_wrap = (cnt == TICK_W'(CLKS_PER_SEC - 1));   // last cycle of the second
    assign at_mid  = (cnt == TICK_W'(CLKS_PER_HALF - 1));  // last cycle of first half

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (at_wrap) begin
            cnt <= '0;                           // start the next second
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ticks are registered so they line up with edge CLKS_PER_SEC after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            tick_sec  <= 1'b0;
            tick_half <= 1'b0;
        end else begin
            tick_sec  <= at_wrap;                // wrap only
            tick_half <= at_wrap | at_mid;       // midpoint and wrap
        end
    end

endmodule

// ==== meter_ctrl.sv ====
`timescale 1ns/1ps

module meter_ctrl import meter_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   add1,                         // 60 s coin
    input  logic   add2,                         // 120 s coin
    input  logic   add3,                         // 180 s coin
    input  logic   add4,                         // 300 s coin
    input  logic   preset_16,
    input  logic   preset_150,
    timer_if.ctrl  tmr
);

    meter_state_t state;
    meter_state_t state_nxt;
    logic [3:0]   coins;                         // add4 down to add1
    logic         coin_hit;                      // exactly one coin button high
    logic         coin_ok;                       // coin press that counts this cycle
    time_t        coin_amount;
    logic         preset_16_q;                   // previous preset levels
    logic         preset_150_q;
    logic         load_16;
    logic         load_150;
    logic         preset_hit;
    time_t        preset_amount;

    assign coins = {add4, add3, add2, add1};

    // one-hot coin decode
    always_comb begin
        coin_hit    = 1'b1;
        coin_amount = COIN_1;
        case (coins)
            4'b0001: coin_amount = COIN_1;
            4'b0010: coin_amount = COIN_2;
            4'b0100: coin_amount = COIN_3;
            4'b1000: coin_amount = COIN_4;
            default: coin_hit = 1'b0;            // none or several pressed
        endcase
    end

    // a preset counts on its rising edge and only when the other one is low
    assign load_16       = preset_16 & ~preset_16_q & ~preset_150;
    assign load_150      = preset_150 & ~preset_150_q & ~preset_16;
    assign preset_hit    = load_16 | load_150;
    assign preset_amount = load_16 ? PRESET_SHORT : PRESET_LONG;

    assign coin_ok = coin_hit && (state != HELD);  // held button was already counted

    // timer commands act on the same edge that samples the buttons
    assign tmr.load     = preset_hit;
    assign tmr.add      = coin_ok && !preset_hit;   // preset wins
    assign tmr.amount   = preset_hit ? preset_amount : coin_amount;
    assign tmr.count_en = (state == RUN);

    always_comb begin
        state_nxt = state;
        if (preset_hit) begin
            // stay in HELD while a coin is still down so it is not added again
            state_nxt = (|coins) ? HELD : RUN;
        end else begin
            case (state)
                IDLE: begin
                    if (coin_hit) state_nxt = HELD;
                end
                HELD: begin
                    if (coins == 4'b0000) state_nxt = RUN;   // all released
                end
                RUN: begin
                    if (coin_hit) begin
                        state_nxt = HELD;        // topped up while counting
                    end else if (tmr.is_zero) begin
                        state_nxt = IDLE;        // time ran out
                    end
                end
                default: state_nxt = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            preset_16_q  <= 1'b0;
            preset_150_q <= 1'b0;
        end else begin
            state        <= state_nxt;
            preset_16_q  <= preset_16;
            preset_150_q <= preset_150;
        end
    end

endmodule

// ==== time_counter.sv ====
`timescale 1ns/1ps

module time_counter import meter_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      tick_sec,                  // one second enable
    timer_if.counter  tmr,
    output time_t     time_left                  // remaining seconds
);

    logic [TIME_W:0] sum;                        // one extra bit for the carry
    time_t           sum_sat;
    logic            dec;

    assign sum     = {1'b0, time_left} + {1'b0, tmr.amount};
    assign sum_sat = (sum > {1'b0, TIME_MAX}) ? TIME_MAX : sum[TIME_W-1:0];  // clamp at 9999

    assign dec = tick_sec && tmr.count_en && (time_left != '0);  // never below zero

    always_ff @(posedge clk) begin
        if (rst) begin
            time_left <= '0;
        end else if (tmr.load) begin
            time_left <= tmr.amount;             // preset overwrites
        end else if (tmr.add) begin
            time_left <= sum_sat;
        end else if (dec) begin
            time_left <= time_left - 1'b1;
        end
    end

    assign tmr.is_zero = (time_left == '0);      // from the register itself

endmodule

// ==== bcd_converter.sv ====
`timescale 1ns/1ps

module bcd_converter import meter_pkg::*; (
    input  time_t     time_left,
    output bcd_time_t digits                     // ones at index 0
);

    logic [BCD_W+TIME_W-1:0] scratch;            // bcd field above the binary field

    // double dabble, one step per input bit
    always_comb begin
        scratch = '0;
        scratch[TIME_W-1:0] = time_left;
        for (int step = 0; step < TIME_W; step++) begin
            for (int d = 0; d < 4; d++) begin
                if (scratch[TIME_W + 4*d +: 4] > 4'd4) begin
                    scratch[TIME_W + 4*d +: 4] = scratch[TIME_W + 4*d +: 4] + 4'd3;
                end
            end
            scratch = scratch << 1;
        end
        digits = scratch[TIME_W +: BCD_W];       // top 16 bits hold the digits
    end

endmodule

// ==== display_driver.sv ====
`timescale 1ns/1ps

module display_driver import meter_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick_half,                // half second enable
    input  time_t      time_left,
    input  bcd_time_t  digits,
    output logic [3:0] an,                       // active low digit enables
    output logic [6:0] led_seg                   // active low, segment a on bit 6
);

    logic [1:0]  blink_phase;                    // counts half seconds
    logic [1:0]  refresh_idx;                    // digit being driven
    bcd_digit_t  cur_digit;
    logic [3:0]  an_lit;
    logic        fast_blank;
    logic        slow_blank;

    always_ff @(posedge clk) begin
        if (rst) begin
            blink_phase <= 2'd0;
        end else if (tick_half) begin
            blink_phase <= blink_phase + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_idx <= 2'd0;
        end else begin
            refresh_idx <= refresh_idx + 2'd1;   // next digit every clk
        end
    end

    assign cur_digit = digits[refresh_idx];

    // only the selected digit is pulled low
    always_comb begin
        case (refresh_idx)
            2'd0:    an_lit = 4'b1110;
            2'd1:    an_lit = 4'b1101;
            2'd2:    an_lit = 4'b1011;
            default: an_lit = 4'b0111;
        endcase
    end

    assign fast_blank = (time_left == '0) && blink_phase[0];  // half second blink at zero
    assign slow_blank = (time_left != '0) && (time_left <= SLOW_BLINK_LIMIT)
                        && blink_phase[1];                    // one second blink when low

    assign an = (fast_blank || slow_blank) ? 4'b1111 : an_lit;

    // cathode patterns, bit 6 is segment a and bit 0 is segment g
    always_comb begin
        case (cur_digit)
            4'd0:    led_seg = 7'b0000001;
            4'd1:    led_seg = 7'b1001111;
            4'd2:    led_seg = 7'b0010010;
            4'd3:    led_seg = 7'b0000110;
            4'd4:    led_seg = 7'b1001100;
            4'd5:    led_seg = 7'b0100100;
            4'd6:    led_seg = 7'b0100000;
            4'd7:    led_seg = 7'b0001111;
            4'd8:    led_seg = 7'b0000000;
            4'd9:    led_seg = 7'b0000100;
            default: led_seg = 7'b1111111;       // not a decimal digit so all dark
        endcase
    end

endmodule

// ==== parking_meter.sv ====
`timescale 1ns/1ps

module parking_meter import meter_pkg::*; (
    input  logic       clk,                      // 100 Hz
    input  logic       rst,
    input  logic       add1,
    input  logic       add2,
    input  logic       add3,
    input  logic       add4,
    input  logic       preset_16,
    input  logic       preset_150,
    output logic [3:0] an,
    output logic [6:0] led_seg,
    output logic [3:0] val1,                     // ones
    output logic [3:0] val2,                     // tens
    output logic [3:0] val3,                     // hundreds
    output logic [3:0] val4                      // thousands
);

    logic      tick_sec;
    logic      tick_half;
    time_t     time_left;
    bcd_time_t digits;

    timer_if tmr_if ();                          // ctrl to counter link

    tick_gen tick_gen_i (
        .clk       (clk),
        .rst       (rst),
        .tick_sec  (tick_sec),
        .tick_half (tick_half)
    );

    meter_ctrl meter_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .add1       (add1),
        .add2       (add2),
        .add3       (add3),
        .add4       (add4),
        .preset_16  (preset_16),
        .preset_150 (preset_150),
        .tmr        (tmr_if.ctrl)
    );

    time_counter time_counter_i (
        .clk       (clk),
        .rst       (rst),
        .tick_sec  (tick_sec),
        .tmr       (tmr_if.counter),
        .time_left (time_left)
    );

    bcd_converter bcd_converter_i (
        .time_left (time_left),
        .digits    (digits)
    );

    display_driver display_driver_i (
        .clk       (clk),
        .rst       (rst),
        .tick_half (tick_half),
        .time_left (time_left),
        .digits    (digits),
        .an        (an),
        .led_seg   (led_seg)
    );

    assign val1 = digits[0];
    assign val2 = digits[1];
    assign val3 = digits[2];
    assign val4 = digits[3];

endmodule

// ==== parking_meter_properties.sv ====
`timescale 1ns/1ps

module parking_meter_properties import meter_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic [3:0]   coins,                   // add4 down to add1
    input logic         load,
    input logic         add,
    input logic         count_en,
    input meter_state_t state
);

    // a coin or a preset over a held coin parks the fsm until release
    press_waits_for_release: assert property (
        @(posedge clk) disable iff (rst)
            (add || (load && coins != 4'b0000)) |=> (state == HELD)
    ) else $error("press did not move the fsm to HELD");

    // a held coin is added once
    add_single_pulse: assert property (
        @(posedge clk) disable iff (rst) add |=> !add
    ) else $error("add held high for more than one cycle");

    // counting only starts once every coin button is up
    count_starts_after_release: assert property (
        @(posedge clk) disable iff (rst) $rose(count_en) |-> $past(coins == 4'b0000)
    ) else $error("count_en rose while a coin button was down");

endmodule

bind meter_ctrl parking_meter_properties props_i (
    .clk      (clk),
    .rst      (rst),
    .coins    (coins),
    .load     (tmr.load),
    .add      (tmr.add),
    .count_en (tmr.count_en),
    .state    (state)
);

// ==== tb_parking_meter.sv ====
`timescale 1ns/1ps

module tb_parking_meter import meter_pkg::*; ();

    localparam logic [5:0] B_ADD1 = 6'b000001;   // button masks in {p150, p16, add4..add1} order
    localparam logic [5:0] B_ADD2 = 6'b000010;
    localparam logic [5:0] B_ADD4 = 6'b001000;
    localparam logic [5:0] B_P16  = 6'b010000;
    localparam logic [5:0] B_P150 = 6'b100000;

    logic        clk;
    logic        rst;
    logic        add1;
    logic        add2;
    logic        add3;
    logic        add4;
    logic        preset_16;
    logic        preset_150;
    logic [3:0]  an;
    logic [6:0]  led_seg;
    logic [3:0]  val1;                           // ones
    logic [3:0]  val2;
    logic [3:0]  val3;
    logic [3:0]  val4;                           // thousands

    int          cyc;                            // rising edges since rst fell
    int          exp_base;                       // model time at the last load or add
    int          base_decs;                      // tick count when exp_base was set
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    logic [15:0] lfsr;

    parking_meter parking_meter_i (
        .clk(clk), .rst(rst),
        .add1(add1), .add2(add2), .add3(add3), .add4(add4),
        .preset_16(preset_16), .preset_150(preset_150),
        .an(an), .led_seg(led_seg),
        .val1(val1), .val2(val2), .val3(val3), .val4(val4)
    );

    always #10 clk = ~clk;                       // 20 ns period

    always @(posedge clk) begin
        if (rst) cyc <= 0;
        else     cyc <= cyc + 1;
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;    // galois taps 16,14,13,11
        return s >> 1;
    endfunction

    // decrements land on the edge after each second tick
    function automatic int decs_at(int c);
        return (c >= 1) ? (c - 1) / CLKS_PER_SEC : 0;
    endfunction

    function automatic int phase_at(int c);
        return (c >= 1) ? ((c - 1) / CLKS_PER_HALF) % 4 : 0;  // blink phase after edge c
    endfunction

    function automatic int sat(int v);
        return (v > int'(TIME_MAX)) ? int'(TIME_MAX) : v;
    endfunction

    function automatic logic [15:0] to_bcd(int t);
        return {4'(t / 1000 % 10), 4'(t / 100 % 10), 4'(t / 10 % 10), 4'(t % 10)};
    endfunction

    function automatic logic [6:0] seg_of(logic [3:0] d);
        case (d)                                 // segments abcdefg with low lit
            4'd0: return 7'b0000001;
            4'd1: return 7'b1001111;
            4'd2: return 7'b0010010;
            4'd3: return 7'b0000110;
            4'd4: return 7'b1001100;
            4'd5: return 7'b0100100;
            4'd6: return 7'b0100000;
            4'd7: return 7'b0001111;
            4'd8: return 7'b0000000;
            4'd9: return 7'b0000100;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic int expected_time();
        int t;
        t = exp_base - (decs_at(cyc) - base_decs);
        return (t < 0) ? 0 : t;                  // counter stops at zero
    endfunction

    task automatic check_value(string name, string what, logic [15:0] exp, logic [15:0] act);
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            test_errs++;
        end
    endtask

    // compares time, anodes and segments with the model at the current cycle
    task automatic compare_outputs(string name);
        int          t;
        int          ph;
        logic [1:0]  k;
        logic        blank;
        logic [15:0] bcd;
        t     = expected_time();
        bcd   = to_bcd(t);
        ph    = phase_at(cyc);
        k     = 2'(cyc % 4);                     // refresh index steps every clk
        blank = (t == 0 && ph % 2 == 1) || (t > 0 && t <= int'(SLOW_BLINK_LIMIT) && ph >= 2);
        check_value(name, "time", bcd, {val4, val3, val2, val1});
        if (blank) begin
            check_value(name, "an", 16'h000f, {12'h0, an});
        end else begin
            check_value(name, "an", {12'h0, 4'b1111 ^ (4'b0001 << k)}, {12'h0, an});
            check_value(name, "led_seg", {9'h0, seg_of(bcd[4*k +: 4])}, {9'h0, led_seg});
        end
    endtask

    task automatic abort_run(string why);
        $display("timeout: %s", why);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic set_buttons(logic [5:0] b);
        {preset_150, preset_16, add4, add3, add2, add1} = b;
    endtask

    task automatic run_until(string name, int target);
        int guard;
        guard = 0;
        while (cyc < target && guard < 10000) begin
            @(negedge clk);
            compare_outputs(name);
            guard++;
        end
        if (cyc < target) abort_run({name, " never reached its end cycle"});
    endtask

    task automatic do_reset();
        rst = 1'b1;
        set_buttons(6'b0);
        repeat (10) @(negedge clk);
        rst       = 1'b0;                        // released on a falling edge
        exp_base  = 0;
        base_decs = 0;
    endtask

    // press for hold cycles; the new time shows one cycle after the press
    task automatic apply(string name, logic [5:0] b, int new_time, int hold);
        set_buttons(b);
        @(negedge clk);
        exp_base  = new_time;
        base_decs = decs_at(cyc);
        compare_outputs(name);
        repeat (hold - 1) begin
            @(negedge clk);
            compare_outputs(name);
        end
        set_buttons(6'b0);
        @(negedge clk);
        compare_outputs(name);                   // release must not add again
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic after_reset();
        do_reset();
        compare_outputs("reset_display");
        run_until("reset_display", 2 * CLKS_PER_HALF + 1);  // lit half then dark half
        finish_test("reset_display");
    endtask

    task automatic coin_sums();
        logic [1:0] sel;
        int         amt;
        do_reset();
        repeat (8) begin                         // all before the first tick
            sel[0] = lfsr[0];
            lfsr   = lfsr_step(lfsr);
            sel[1] = lfsr[0];
            lfsr   = lfsr_step(lfsr);
            case (sel)
                2'd0:    amt = int'(COIN_1);
                2'd1:    amt = int'(COIN_2);
                2'd2:    amt = int'(COIN_3);
                default: amt = int'(COIN_4);
            endcase
            apply("coins", B_ADD1 << sel, sat(expected_time() + amt), 3);
        end
        finish_test("coins");
    endtask

    task automatic countdown_from_coin();
        do_reset();
        apply("countdown", B_ADD4, int'(COIN_4), 2);
        run_until("countdown", 5 * CLKS_PER_SEC + 2);     // five ticks checked every cycle
        finish_test("countdown");
    endtask

    task automatic saturate_at_max();
        do_reset();
        repeat (37) apply("saturation", B_ADD4, sat(expected_time() + int'(COIN_4)), 1);
        finish_test("saturation");               // 34 presses reach the cap and 3 more stay there
    endtask

    task automatic preset_loads();
        do_reset();
        apply("presets", B_P16, int'(PRESET_SHORT), 1);
        run_until("presets", 16 * CLKS_PER_SEC + 5);      // ran out
        apply("presets", B_ADD1, int'(COIN_1), 2);        // idle meter takes a coin
        run_until("presets", 17 * CLKS_PER_SEC + 10);
        apply("presets", B_P150, int'(PRESET_LONG), 1);   // overwrite mid countdown
        run_until("presets", 18 * CLKS_PER_SEC + 50);
        finish_test("presets");
    endtask

    task automatic blink_near_limit();
        do_reset();
        apply("display", B_ADD2, int'(COIN_2), 2);
        run_until("display", 22 * CLKS_PER_SEC + 2);      // slow blink down past 100
        finish_test("display");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        set_buttons(6'b0);
        lfsr         = 16'd15;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_base     = 0;
        base_decs    = 0;
        after_reset();
        coin_sums();
        countdown_from_coin();
        saturate_at_max();
        preset_loads();
        blink_near_limit();
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
meter_pkg.sv
timer_if.sv
tick_gen.sv
meter_ctrl.sv
time_counter.sv
bcd_converter.sv
display_driver.sv
parking_meter.sv
parking_meter_properties.sv
tb_parking_meter.sv

// ==== Makefile ====
SRCS := $(shell cat filelist.f)
SIM  := obj_dir/Vtb_parking_meter

.PHONY: all run clean

all: $(SIM)

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_parking_meter -f filelist.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
